// ==== build.f ====
hw/psg_pkg.sv
hw/psg_regs_if.sv
hw/cpu_bus_sync.sv
hw/psg_regs.sv
hw/psg_oscillators.sv
hw/psg_envelope.sv
hw/psg_mix_dac.sv
hw/psg_top.sv
verif/tb_clkgen.sv
verif/psg_sva.sv
verif/psg_checker.sv
verif/psg_tb.sv

// ==== hw/cpu_bus_sync.sv ====
// CPU bus synchroniser
// brings the asynchronous CPU write and read strobes into the clk domain
// as one-cycle ticks, captures the write data and address port select
// and holds the read data for the CPU between reads

`default_nettype none

module cpu_bus_sync import psg_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         a0,           // port select, held steady through the write
    input  wire  [7:0]  wdata,
    input  wire         cpu_wr,       // asynchronous level
    input  wire         cpu_rd,       // asynchronous level
    input  wire  [7:0]  reg_rdata,
    output logic        wr_tick,
    output logic        rd_tick,
    output logic [7:0]  wr_data,
    output logic        addr_sel,
    output logic [7:0]  rdata
);

    logic [SYNC_LEN-1:0] wr_sync;     // bit 0 is the newest sample
    logic [SYNC_LEN-1:0] rd_sync;
    logic                wr_rise;
    logic                rd_rise;

    // rising edge seen between the last two synchroniser stages
    assign wr_rise = wr_sync[SYNC_LEN-2] & ~wr_sync[SYNC_LEN-1];
    assign rd_rise = rd_sync[SYNC_LEN-2] & ~rd_sync[SYNC_LEN-1];

    // **************************************************
    // strobe synchronisers and ticks
    // **************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_sync <= '0;
            rd_sync <= '0;
            wr_tick <= 1'b0;
            rd_tick <= 1'b0;
            rdata   <= 8'h00;
        end else begin
            wr_sync <= {wr_sync[SYNC_LEN-2:0], cpu_wr};
            rd_sync <= {rd_sync[SYNC_LEN-2:0], cpu_rd};
            wr_tick <= wr_rise;
            rd_tick <= rd_rise;
            if (rd_tick) begin
                rdata <= reg_rdata;                // held until the next read completes
            end
        end
    end

    // bus values are sampled on the edge that forms the write tick
    always_ff @(posedge clk) begin
        if (wr_rise) begin
            wr_data  <= wdata;
            addr_sel <= a0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/psg_envelope.sv ====
// PSG envelope generator
// a 16-bit period counter steps a 4-bit level up or down, and at the end
// of each ramp the shape bits decide whether it holds, inverts, turns
// around, wraps to the start level or drops to zero

`default_nettype none

module psg_envelope import psg_pkg::*; (
    input  wire                clk,
    input  wire                rst,
    psg_regs_if.env            rif,
    output logic [LEVEL_W-1:0] env_level
);

    logic [ENV_PER_W-1:0] per_cnt;
    logic [LEVEL_W-1:0]   level;
    logic                 dir_up;         // current ramp direction
    logic                 holding;        // level frozen until the next restart
    logic                 ramp_end;
    logic                 sh_cont;
    logic                 sh_att;
    logic                 sh_alt;
    logic                 sh_hold;

    assign sh_cont = rif.env_shape[SH_CONT];
    assign sh_att  = rif.env_shape[SH_ATT];
    assign sh_alt  = rif.env_shape[SH_ALT];
    assign sh_hold = rif.env_shape[SH_HOLD];

    assign ramp_end  = dir_up ? (level == '1) : (level == '0);
    assign env_level = level;

    // **************************************************
    // period counter and shape stepper
    // **************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            per_cnt <= '0;
            level   <= '0;
            dir_up  <= 1'b0;
            holding <= 1'b1;               // shape 0 after reset rests at zero
        end else if (rif.env_restart) begin
            // a shape write restarts the ramp from the shape's start level
            per_cnt <= rif.env_period;
            level   <= sh_att ? '0 : '1;
            dir_up  <= sh_att;
            holding <= 1'b0;
        end else if (rif.step) begin
            if (per_cnt < ENV_PER_W'(2)) begin
                per_cnt <= rif.env_period;
                if (!holding) begin
                    if (!ramp_end) begin
                        level <= dir_up ? level + 1'b1 : level - 1'b1;
                    end else if (!sh_cont) begin
                        level   <= '0;             // single ramp, then silence
                        holding <= 1'b1;
                    end else if (sh_hold) begin
                        holding <= 1'b1;
                        if (sh_alt) begin
                            level <= ~level;       // hold at the opposite end
                        end
                    end else if (sh_alt) begin
                        dir_up <= ~dir_up;         // triangle, turn around
                    end else begin
                        level <= dir_up ? '0 : '1; // sawtooth, back to the start
                    end
                end
            end else begin
                per_cnt <= per_cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/psg_mix_dac.sv ====
// PSG mixer and DAC
// gates each channel by its enabled tone and noise sources, selects a fixed
// or envelope amplitude and turns it into a pulse-density 1-bit output

`default_nettype none

module psg_mix_dac import psg_pkg::*; (
    input  wire                clk,
    input  wire                rst,
    input  wire  [NUM_CH-1:0]  tone,
    input  wire                noise,
    input  wire  [LEVEL_W-1:0] env_level,
    psg_regs_if.mix            rif,
    output logic [NUM_CH-1:0]  aout
);

    logic [LEVEL_W-1:0] dac_cnt;                  // shared by all channels, 0 to 14
    logic [NUM_CH-1:0]  gate;
    logic [LEVEL_W-1:0] ch_level [NUM_CH];

    // **************************************************
    // gate and amplitude select per channel
    // **************************************************
    always_comb begin
        for (int n = 0; n < NUM_CH; n++) begin
            // a disabled source counts as permanently high
            gate[n] = (tone[n] | rif.mixer[n]) & (noise | rif.mixer[NUM_CH + n]);
            ch_level[n] = rif.amp[n][AMP_W-1] ? env_level : rif.amp[n][LEVEL_W-1:0];
        end
    end

    // over one DAC cycle the output is high for exactly ch_level clocks
    always_ff @(posedge clk) begin
        if (rst) begin
            dac_cnt <= '0;
            aout    <= '0;
        end else begin
            dac_cnt <= (dac_cnt == LEVEL_W'(DAC_STEPS - 1)) ? '0 : dac_cnt + 1'b1;
            for (int n = 0; n < NUM_CH; n++) begin
                aout[n] <= gate[n] & (dac_cnt < ch_level[n]);    // level 15 stays high
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/psg_oscillators.sv ====
// PSG tone and noise sources
// three square-wave tone counters and a 17-bit noise LFSR, all advanced
// on the prescaler step, a period of zero behaves as a period of one

`default_nettype none

module psg_oscillators import psg_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    psg_regs_if.osc           rif,
    output logic [NUM_CH-1:0] tone,
    output logic              noise
);

    logic [TONE_W-1:0]  tone_cnt [NUM_CH];
    logic [NOISE_W-1:0] noise_cnt;
    logic [LFSR_W-1:0]  lfsr;
    logic               lfsr_fb;

    // taps 17 and 14, the register never reaches the all-zero state
    assign lfsr_fb = lfsr[LFSR_W-1] ^ lfsr[LFSR_W-4];
    assign noise   = lfsr[0];

    // **************************************************
    // tone down-counters
    // **************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            tone <= '0;
            for (int n = 0; n < NUM_CH; n++) begin
                tone_cnt[n] <= '0;
            end
        end else if (rif.step) begin
            for (int n = 0; n < NUM_CH; n++) begin
                if (tone_cnt[n] < TONE_W'(2)) begin
                    // expiry, reload from the register so new periods take hold here
                    tone_cnt[n] <= rif.tone_period[n];
                    tone[n]     <= ~tone[n];
                end else begin
                    tone_cnt[n] <= tone_cnt[n] - 1'b1;
                end
            end
        end
    end

    // noise period counter clocks the LFSR
    always_ff @(posedge clk) begin
        if (rst) begin
            noise_cnt <= '0;
            lfsr      <= LFSR_W'(1);               // seed
        end else if (rif.step) begin
            if (noise_cnt < NOISE_W'(2)) begin
                noise_cnt <= rif.noise_period;
                lfsr      <= {lfsr[LFSR_W-2:0], lfsr_fb};
            end else begin
                noise_cnt <= noise_cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/psg_pkg.sv ====
// PSG shared definitions
// register indices, field widths, prescaler and synchroniser constants
// and the mask of implemented bits in each of the sixteen registers

`default_nettype none

package psg_pkg;

    // **************************************************
    // timing constants
    // **************************************************
    localparam int SYNC_LEN  = 3;                  // CPU strobe synchroniser depth
    localparam int PRESCALE  = 8;                  // clocks per generator step
    localparam int PRE_W     = $clog2(PRESCALE);
    localparam int DAC_STEPS = 15;                 // DAC counter runs 0 to 14

    // field widths
    localparam int NUM_CH    = 3;
    localparam int REG_COUNT = 16;
    localparam int TONE_W    = 12;
    localparam int NOISE_W   = 5;
    localparam int LFSR_W    = 17;
    localparam int MIXER_W   = 6;                  // 3 tone disables, then 3 noise disables
    localparam int AMP_W     = 5;                  // bit 4 selects the envelope
    localparam int LEVEL_W   = 4;
    localparam int ENV_PER_W = 16;
    localparam int SHAPE_W   = 4;

    // envelope shape bit positions
    localparam int SH_HOLD = 0;
    localparam int SH_ALT  = 1;
    localparam int SH_ATT  = 2;
    localparam int SH_CONT = 3;

    typedef logic [3:0] reg_idx_t;

    // **************************************************
    // register map
    // **************************************************
    localparam reg_idx_t R_TONE_A_LO = 4'd0;
    localparam reg_idx_t R_TONE_A_HI = 4'd1;
    localparam reg_idx_t R_TONE_B_LO = 4'd2;
    localparam reg_idx_t R_TONE_B_HI = 4'd3;
    localparam reg_idx_t R_TONE_C_LO = 4'd4;
    localparam reg_idx_t R_TONE_C_HI = 4'd5;
    localparam reg_idx_t R_NOISE     = 4'd6;
    localparam reg_idx_t R_MIXER     = 4'd7;
    localparam reg_idx_t R_AMP_A     = 4'd8;
    localparam reg_idx_t R_AMP_B     = 4'd9;
    localparam reg_idx_t R_AMP_C     = 4'd10;
    localparam reg_idx_t R_ENV_LO    = 4'd11;
    localparam reg_idx_t R_ENV_HI    = 4'd12;
    localparam reg_idx_t R_ENV_SHAPE = 4'd13;

    // implemented bits per register, the I/O ports 14 and 15 read as zero
    localparam logic [7:0] REG_MASK [REG_COUNT] = '{
        8'hFF, 8'h0F, 8'hFF, 8'h0F, 8'hFF, 8'h0F, 8'h1F, 8'hFF,
        8'h1F, 8'h1F, 8'h1F, 8'hFF, 8'hFF, 8'h0F, 8'h00, 8'h00
    };

endpackage

`default_nettype wire

// ==== hw/psg_regs.sv ====
// PSG control block
// holds the address latch and the sixteen registers, masks stored values
// to their implemented bits, returns read data, derives the prescaler step
// and signals an envelope restart on every write to the shape register

`default_nettype none

module psg_regs import psg_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         wr_tick,      // one cycle per CPU write
    input  wire         rd_tick,      // one cycle per CPU read
    input  wire  [7:0]  wr_data,
    input  wire         addr_sel,     // 0 selects the address latch, 1 the data register
    output logic [7:0]  reg_rdata,
    psg_regs_if.regs    rif
);

    reg_idx_t          reg_idx;                   // currently selected register
    logic [7:0]        reg_file [REG_COUNT];
    logic [PRE_W-1:0]  pre_cnt;
    logic              step_q;
    logic              env_restart_q;

    // **************************************************
    // CPU side of the register file
    // **************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_idx       <= '0;
            env_restart_q <= 1'b0;
            for (int i = 0; i < REG_COUNT; i++) begin
                reg_file[i] <= '0;
            end
        end else begin
            env_restart_q <= 1'b0;                 // pulse lasts a single cycle
            if (wr_tick) begin
                if (!addr_sel) begin
                    reg_idx <= wr_data[3:0];       // upper address bits are ignored
                end else begin
                    // only implemented bits are kept so readback comes out masked
                    reg_file[reg_idx] <= wr_data & REG_MASK[reg_idx];
                    env_restart_q     <= (reg_idx == R_ENV_SHAPE);
                end
            end
        end
    end

    // the return bus is only driven while a read is in progress
    assign reg_rdata = rd_tick ? reg_file[reg_idx] : 8'h00;

    // prescaler, one step every PRESCALE clocks
    always_ff @(posedge clk) begin
        if (rst) begin
            pre_cnt <= '0;
            step_q  <= 1'b0;
        end else begin
            step_q  <= (pre_cnt == PRE_W'(PRESCALE - 1));
            pre_cnt <= (pre_cnt == PRE_W'(PRESCALE - 1)) ? '0 : pre_cnt + 1'b1;
        end
    end

    // **************************************************
    // field unpacking onto the generator bundle
    // **************************************************
    assign rif.tone_period[0] = {reg_file[R_TONE_A_HI][3:0], reg_file[R_TONE_A_LO]};
    assign rif.tone_period[1] = {reg_file[R_TONE_B_HI][3:0], reg_file[R_TONE_B_LO]};
    assign rif.tone_period[2] = {reg_file[R_TONE_C_HI][3:0], reg_file[R_TONE_C_LO]};
    assign rif.noise_period   = reg_file[R_NOISE][NOISE_W-1:0];
    assign rif.mixer          = reg_file[R_MIXER][MIXER_W-1:0];    // I/O enables dropped
    assign rif.amp[0]         = reg_file[R_AMP_A][AMP_W-1:0];
    assign rif.amp[1]         = reg_file[R_AMP_B][AMP_W-1:0];
    assign rif.amp[2]         = reg_file[R_AMP_C][AMP_W-1:0];
    assign rif.env_period     = {reg_file[R_ENV_HI], reg_file[R_ENV_LO]};
    assign rif.env_shape      = reg_file[R_ENV_SHAPE][SHAPE_W-1:0];
    assign rif.env_restart    = env_restart_q;
    assign rif.step           = step_q;

endmodule

`default_nettype wire

// ==== hw/psg_regs_if.sv ====
// PSG register field bundle
// carries the decoded register fields and the step and restart pulses
// from the register file out to the tone, noise, envelope and mixer blocks

`default_nettype none

interface psg_regs_if import psg_pkg::*; ();

    logic [TONE_W-1:0]    tone_period [NUM_CH];   // half period of each square wave, in steps
    logic [NOISE_W-1:0]   noise_period;           // LFSR shift period, in steps
    logic [MIXER_W-1:0]   mixer;                  // a set bit disables that source
    logic [AMP_W-1:0]     amp [NUM_CH];           // fixed level, or envelope when bit 4 set
    logic [ENV_PER_W-1:0] env_period;             // envelope step period, in steps
    logic [SHAPE_W-1:0]   env_shape;
    logic                 env_restart;            // one cycle after a write to register 13
    logic                 step;                   // prescaler strobe

    // the register file owns every field
    modport regs (
        output tone_period, noise_period, mixer, amp,
        output env_period, env_shape, env_restart, step
    );

    // tone counters and noise LFSR
    modport osc (
        input tone_period, noise_period, step
    );

    // envelope generator
    modport env (
        input env_period, env_shape, env_restart, step
    );

    // channel gates and amplitude select
    modport mix (
        input mixer, amp
    );

endinterface

`default_nettype wire

// ==== hw/psg_top.sv ====
// PSG subsystem top level
// CPU bus synchroniser, register file, tone and noise sources, envelope
// and mixer DAC, three 1-bit audio outputs

`default_nettype none

module psg_top (
    input  wire         clk,
    input  wire         rst,
    input  wire         a0,
    input  wire  [7:0]  wdata,
    input  wire         cpu_wr,
    input  wire         cpu_rd,
    output logic [7:0]  rdata,
    output logic [2:0]  aout
);

    // bus path between the synchroniser and the register file
    logic       wr_tick;
    logic       rd_tick;
    logic [7:0] wr_data;
    logic       addr_sel;
    logic [7:0] reg_rdata;

    // generator outputs into the mixer
    logic [2:0] tone;
    logic       noise;
    logic [3:0] env_level;

    psg_regs_if regs_bus ();

    cpu_bus_sync u_bus_sync (
        .clk       (clk),
        .rst       (rst),
        .a0        (a0),
        .wdata     (wdata),
        .cpu_wr    (cpu_wr),
        .cpu_rd    (cpu_rd),
        .reg_rdata (reg_rdata),
        .wr_tick   (wr_tick),
        .rd_tick   (rd_tick),
        .wr_data   (wr_data),
        .addr_sel  (addr_sel),
        .rdata     (rdata)
    );

    psg_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .wr_tick   (wr_tick),
        .rd_tick   (rd_tick),
        .wr_data   (wr_data),
        .addr_sel  (addr_sel),
        .reg_rdata (reg_rdata),
        .rif       (regs_bus.regs)
    );

    psg_oscillators u_osc (
        .clk       (clk),
        .rst       (rst),
        .rif       (regs_bus.osc),
        .tone      (tone),
        .noise     (noise)
    );

    psg_envelope u_env (
        .clk       (clk),
        .rst       (rst),
        .rif       (regs_bus.env),
        .env_level (env_level)
    );

    psg_mix_dac u_mix (
        .clk       (clk),
        .rst       (rst),
        .tone      (tone),
        .noise     (noise),
        .env_level (env_level),
        .rif       (regs_bus.mix),
        .aout      (aout)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the PSG testbench with Verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f build.f --top-module psg_tb -o psg_sim

# the simulator status is not trusted alone, the log decides
./obj_dir/psg_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// ==== verif/psg_checker.sv ====
// PSG response checker
// compares read data against queued expected values, measures aout run
// lengths and duty and counts errors per test and over the whole run

`default_nettype none

module psg_checker (
    input wire       clk,
    input wire       cpu_rd,
    input wire [7:0] rdata,
    input wire [2:0] aout
);

    logic [7:0] exp_q [$];                 // expected read values with the oldest first
    string      name_q [$];
    int         checks     = 0;
    int         errors     = 0;
    int         tests      = 0;
    int         errs_start = 0;            // error count when the current test began
    string      cur_test   = "none";

    // **************************************************
    // bookkeeping
    // **************************************************
    task automatic start_test(input string name);
        cur_test   = name;
        errs_start = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == errs_start) $display("test %s: pass", cur_test);
        else $display("test %s: fail, %0d errors", cur_test, errors - errs_start);
    endtask

    task automatic compare(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("ERROR %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic report(input string msg);
        errors++;
        $display("%s: %s", cur_test, msg);
    endtask

    task automatic summary();
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    endtask

    task automatic expect_read(input string name, input logic [7:0] val);
        exp_q.push_back(val);
        name_q.push_back(name);
    endtask

    // **************************************************
    // read data compare 6 cycles after each cpu_rd rise
    // **************************************************
    initial begin
        forever begin
            @(posedge cpu_rd);
            repeat (6) @(negedge clk);
            if (exp_q.size() == 0) report("read seen with no expected value");
            else compare(name_q.pop_front(), int'(exp_q.pop_front()), int'(rdata));
        end
    end

    task automatic check_rdata(input string name, input logic [7:0] exp);
        @(negedge clk);
        compare(name, int'(exp), int'(rdata));
    endtask

    // aout[ch] must hold val on every cycle of the window
    task automatic check_constant(input string name, input int ch, input logic val,
                                  input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (aout[ch] !== val) begin
                compare(name, int'(val), int'(aout[ch]));
                return;
            end
        end
        checks++;
    endtask

    // the first two runs may be partial or from an older period so only the nruns
    // after them are compared
    task automatic check_runs(input string name, input int ch, input int exp,
                              input int nruns, input int limit);
        logic prev;
        int   len;
        int   edges;
        @(negedge clk);
        prev  = aout[ch];
        len   = 0;
        edges = 0;
        while (edges < nruns + 2) begin
            @(negedge clk);
            len++;
            if (aout[ch] !== prev) begin
                if (edges >= 2) compare(name, exp, len);
                edges++;
                len  = 0;
                prev = aout[ch];
            end else if (len > limit) begin
                report($sformatf("no edge on aout[%0d] within %0d cycles", ch, limit));
                return;
            end
        end
    endtask

    // high count over one DAC cycle of 15 clocks
    task automatic check_duty(input string name, input int ch, input int level);
        int high;
        high = 0;
        for (int i = 0; i < 15; i++) begin
            @(negedge clk);
            if (aout[ch] === 1'b1) high++;
        end
        compare(name, level, high);
    endtask

    // output must change at least once and never sit still longer than max_run
    task automatic check_toggling(input int ch, input int cycles, input int max_run);
        logic prev;
        int   run;
        int   edges;
        @(negedge clk);
        prev  = aout[ch];
        run   = 0;
        edges = 0;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            run++;
            if (aout[ch] !== prev) begin
                edges++;
                run  = 0;
                prev = aout[ch];
            end else if (run > max_run) begin
                report($sformatf("noise output stuck on aout[%0d]", ch));
                return;
            end
        end
        checks++;
        if (edges == 0) report($sformatf("noise output stuck on aout[%0d]", ch));
    endtask

endmodule

`default_nettype wire

// ==== verif/psg_sva.sv ====
// CPU bus synchroniser assertions
// tick width, reset behaviour and read data holding between reads

`default_nettype none

module psg_sva (
    input wire       clk,
    input wire       rst,
    input wire       wr_tick,
    input wire       rd_tick,
    input wire [7:0] rdata
);

    // a tick never lasts more than one cycle
    wr_tick_width: assert property (@(posedge clk) disable iff (rst) wr_tick |=> !wr_tick)
        else $error("write tick held high for more than one cycle");

    rd_tick_width: assert property (@(posedge clk) disable iff (rst) rd_tick |=> !rd_tick)
        else $error("read tick held high for more than one cycle");

    // once reset has been seen for two edges the read tick is cleared
    rd_tick_in_reset: assert property (@(posedge clk) (rst && $past(rst)) |-> !rd_tick)
        else $error("read tick active during reset");

    // rdata only moves on the edge after a read tick
    rdata_hold: assert property (@(posedge clk) disable iff (rst) !$past(rd_tick) |-> $stable(rdata))
        else $error("read data changed without a read");

endmodule

bind cpu_bus_sync psg_sva sva0 (
    .clk     (clk),
    .rst     (rst),
    .wr_tick (wr_tick),
    .rd_tick (rd_tick),
    .rdata   (rdata)
);

`default_nettype wire

// ==== verif/psg_tb.sv ====
// PSG subsystem testbench
// drives the CPU bus through readback, silence, tone, duty, envelope and
// noise tests while the checker does all comparisons

`default_nettype none

module psg_tb import psg_pkg::*; ();

    // cycle budgets per test that the watchdog adds up
    localparam int RST_CYC    = 7;
    localparam int WR_CYC     = 17;                // strobe, hold and idle
    localparam int SET_CYC    = 2 * WR_CYC;
    localparam int N_TONE     = 4;
    localparam int T_SILENCE  = 110;
    localparam int T_READBACK = REG_COUNT * (SET_CYC + WR_CYC);
    localparam int T_TONE     = RST_CYC + 2 * SET_CYC + N_TONE * (SET_CYC + 6 * PRESCALE * 40 + 8);
    localparam int T_DUTY     = RST_CYC + 4 * SET_CYC + 3 * 16;
    localparam int T_ENV      = RST_CYC + 6 * SET_CYC + 2 * (142 + 46);
    localparam int T_NOISE    = RST_CYC + 3 * SET_CYC + 2002;
    localparam int BUDGET     = T_SILENCE + T_READBACK + T_TONE + T_DUTY + T_ENV + T_NOISE;

    logic       clk;
    logic       rst;
    logic       a0;
    logic [7:0] wdata;
    logic       cpu_wr;
    logic       cpu_rd;
    wire  [7:0] rdata;
    wire  [2:0] aout;
    int         seed = 47417;

    tb_clkgen clkgen0 (.clk(clk));

    psg_top dut0 (
        .clk (clk), .rst (rst), .a0 (a0), .wdata (wdata),
        .cpu_wr (cpu_wr), .cpu_rd (cpu_rd), .rdata (rdata), .aout (aout)
    );

    psg_checker chk0 (
        .clk (clk), .cpu_rd (cpu_rd), .rdata (rdata), .aout (aout)
    );

    // readback is the written value cut down to the implemented bits
    function automatic logic [7:0] expected_read(input reg_idx_t idx, input logic [7:0] val);
        return val & REG_MASK[idx];
    endfunction

    // **************************************************
    // bus tasks move the inputs 2 units after the edge
    // **************************************************
    task automatic apply_reset();
        @(posedge clk);
        #2 rst = 1'b1;
        repeat (5) @(posedge clk);
        #2 rst = 1'b0;
    endtask

    task automatic bus_write(input logic sel, input logic [7:0] val);
        @(posedge clk);
        #2;
        a0     = sel;
        wdata  = val;
        cpu_wr = 1'b1;
        repeat (8) @(posedge clk);
        #2 cpu_wr = 1'b0;                          // a0 and wdata stay put through idle
        repeat (8) @(posedge clk);
    endtask

    task automatic set_reg(input reg_idx_t idx, input logic [7:0] val);
        bus_write(1'b0, {4'h0, idx});
        bus_write(1'b1, val);
    endtask

    task automatic bus_read();
        @(posedge clk);
        #2;
        a0     = 1'b1;
        cpu_rd = 1'b1;
        repeat (8) @(posedge clk);
        #2 cpu_rd = 1'b0;
        repeat (8) @(posedge clk);
    endtask

    // watchdog ends the run at the summed budget plus 20 percent
    initial begin
        #(BUDGET * 12 / 10 * 20);
        $display("timeout: tests did not finish within %0d cycles", BUDGET * 12 / 10);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        logic [7:0] val;
        int         per;
        rst    = 1'b1;
        a0     = 1'b0;
        wdata  = 8'h00;
        cpu_wr = 1'b0;
        cpu_rd = 1'b0;
        repeat (5) @(posedge clk);
        #2 rst = 1'b0;

        chk0.start_test("silence");
        chk0.check_rdata("silence", 8'h00);
        for (int n = 0; n < 3; n++) chk0.check_constant("silence", n, 1'b0, 30);
        chk0.end_test();

        chk0.start_test("readback");
        for (int i = 0; i < REG_COUNT; i++) begin
            val = 8'($random(seed));
            set_reg(reg_idx_t'(i), val);
            chk0.expect_read("readback", expected_read(reg_idx_t'(i), val));
            bus_read();
        end
        chk0.end_test();

        // channel A tone only at full amplitude so aout follows the square wave
        chk0.start_test("tone");
        apply_reset();
        set_reg(R_AMP_A, 8'd15);
        set_reg(R_MIXER, 8'h38);
        for (int k = 0; k < N_TONE; k++) begin
            per = 1 + {$random(seed)} % 40;
            set_reg(R_TONE_A_LO, per[7:0]);
            chk0.check_runs("tone", 0, PRESCALE * per, 3, PRESCALE * 82);
        end
        chk0.end_test();

        chk0.start_test("duty");
        apply_reset();
        set_reg(R_MIXER, 8'h3F);
        for (int n = 0; n < 3; n++) begin
            per = {$random(seed)} % 16;
            set_reg(reg_idx_t'(R_AMP_A + n), per[7:0]);
            chk0.check_duty("duty", n, per);
        end
        chk0.end_test();

        // envelope on channel C ramps up and holds high, then ramps down and holds low
        chk0.start_test("envelope");
        apply_reset();
        set_reg(R_MIXER, 8'h3F);
        set_reg(R_AMP_C, 8'h10);
        set_reg(R_ENV_LO, 8'd1);
        set_reg(R_ENV_HI, 8'd0);
        set_reg(R_ENV_SHAPE, 8'd13);
        repeat (142) @(posedge clk);
        chk0.check_constant("envelope", 2, 1'b1, 45);
        set_reg(R_ENV_SHAPE, 8'd9);
        repeat (142) @(posedge clk);
        chk0.check_constant("envelope", 2, 1'b0, 45);
        chk0.end_test();

        chk0.start_test("noise");
        apply_reset();
        set_reg(R_AMP_B, 8'd15);
        set_reg(R_NOISE, 8'd1);
        set_reg(R_MIXER, 8'h2F);                   // noise on B only with all tones off
        chk0.check_toggling(1, 2000, 2 * LFSR_W * PRESCALE);
        chk0.end_test();

        chk0.summary();
        if (chk0.errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/tb_clkgen.sv ====
// testbench clock source
// free running clock with a period of 20 time units

`default_nettype none

module tb_clkgen (
    output logic clk
);

    initial clk = 1'b0;

    always #10 clk = ~clk;    // half period

endmodule

`default_nettype wire
